/* hw/multicomp_pkg.sv */
// Option word layout and baud table must match the host menu order, and baud codes 6 and 7 fall back to 115200
package multicomp_pkg;

	// ==============================
	// Option word layout
	// ==============================
	localparam int opt_width = 32;

	// Host reset request
	localparam int opt_reset_bit = 0;
	// Core choice is two bits wide
	localparam int opt_cpu_lsb = 7;
	// Baud choice is three bits wide
	localparam int opt_baud_lsb = 9;
	// Serial port, 0 console and 1 user port
	localparam int opt_port_bit = 12;
	// Storage controller, 0 core SD and 1 image controller
	localparam int opt_store_bit = 13;
	// RTS/CTS enable
	localparam int opt_flow_bit = 14;
	// Reset the system when an image is mounted
	localparam int opt_mount_reset_bit = 15;

	// ==============================
	// Core codes
	// ==============================
	localparam int num_cores = 4;

	localparam logic [1:0] cpu_z80_cpm    = 2'd0;
	localparam logic [1:0] cpu_z80_basic  = 2'd1;
	localparam logic [1:0] cpu_6502_basic = 2'd2;
	localparam logic [1:0] cpu_6809_basic = 2'd3;

	// ==============================
	// Baud codes and increments
	// ==============================
	localparam int baud_inc_width = 16;

	localparam logic [2:0] baud_115200 = 3'd0;
	localparam logic [2:0] baud_38400  = 3'd1;
	localparam logic [2:0] baud_19200  = 3'd2;
	localparam logic [2:0] baud_9600   = 3'd3;
	localparam logic [2:0] baud_4800   = 3'd4;
	localparam logic [2:0] baud_2400   = 3'd5;

	// Phase increment per code, unused codes run at 115200
	localparam logic [baud_inc_width-1:0] baud_inc_table [8] = '{
		16'd2416, 16'd805, 16'd403, 16'd201,
		16'd101, 16'd50, 16'd2416, 16'd2416
	};

endpackage

/* hw/option_decode.sv */
// Assumes option_word is held steady by the host between updates and treats any nonzero img_size as a usable image
`timescale 1ns/10ps

module option_decode
	import multicomp_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic [opt_width-1:0]      option_word,
	input  logic                      user_button,
	input  logic                      img_mounted,
	input  logic [63:0]               img_size,
	output logic [1:0]                core_sel,
	output logic [baud_inc_width-1:0] baud_inc,
	output logic                      port_user,
	output logic                      flow_en,
	output logic                      store_img,
	output logic                      sys_reset,
	output logic                      vsd_sel
);

	logic [2:0] baud_code;

	// ==============================
	// Option fields
	// ==============================
	assign core_sel  = option_word[opt_cpu_lsb +: 2];
	assign baud_code = option_word[opt_baud_lsb +: 3];
	assign port_user = option_word[opt_port_bit];
	assign flow_en   = option_word[opt_flow_bit];
	assign store_img = option_word[opt_store_bit];

	// Baud code to phase increment
	assign baud_inc = baud_inc_table[baud_code];

	// ==============================
	// Reset sources
	// ==============================
	// Board reset, host menu reset, user button
	// Mount reset only fires while an image is being mounted
	assign sys_reset = reset
		| option_word[opt_reset_bit]
		| user_button
		| (option_word[opt_mount_reset_bit] & img_mounted);

	// ==============================
	// Virtual card select
	// ==============================
	// Sampled on the mount strobe
	// An empty image hands the bus back to the physical card
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vsd_sel <= 1'b0;
		end else if (img_mounted) begin
			vsd_sel <= |img_size;
		end
	end

endmodule

/* hw/core_select.sv */
// Purely combinational and assumes unselected cores keep their outputs at defined levels while held in reset
`timescale 1ns/10ps

module core_select
	import multicomp_pkg::*;
(
	input  logic [1:0]             core_sel,
	input  logic                   sys_reset,
	output logic [num_cores-1:0]   core_run,
	output logic [num_cores-1:0]   core_reset,
	input  logic [num_cores-1:0]   core_pix_ce,
	input  logic [num_cores-1:0]   core_hs,
	input  logic [num_cores-1:0]   core_vs,
	input  logic [num_cores-1:0]   core_hblank,
	input  logic [num_cores-1:0]   core_vblank,
	input  logic [num_cores-1:0]   core_txd,
	input  logic [num_cores-1:0]   core_rts,
	input  logic [num_cores-1:0]   core_sd_cs,
	input  logic [num_cores-1:0]   core_sd_mosi,
	input  logic [num_cores-1:0]   core_sd_sck,
	input  logic [num_cores-1:0]   core_led,
	input  logic [num_cores*2-1:0] core_r,
	input  logic [num_cores*2-1:0] core_g,
	input  logic [num_cores*2-1:0] core_b,
	output logic                   pix_ce,
	output logic                   hs,
	output logic                   vs,
	output logic                   hblank,
	output logic                   vblank,
	output logic [7:0]             vga_r,
	output logic [7:0]             vga_g,
	output logic [7:0]             vga_b,
	output logic                   sel_txd,
	output logic                   sel_rts,
	output logic                   sel_sd_cs,
	output logic                   sel_sd_mosi,
	output logic                   sel_sd_sck,
	output logic                   sel_led
);

	// Bit offset of the selected core in the packed colour vectors
	logic [2:0] col_base;

	assign col_base = {core_sel, 1'b0};

	// ==============================
	// Run enable and resets
	// ==============================
	// Only the chosen core advances
	assign core_run = num_cores'(1) << core_sel;

	// Idle cores stay in reset, all cores during system reset
	assign core_reset = sys_reset ? '1 : ~core_run;

	// ==============================
	// Video
	// ==============================
	assign pix_ce = core_pix_ce[core_sel];
	assign hs     = core_hs[core_sel];
	assign vs     = core_vs[core_sel];
	assign hblank = core_hblank[core_sel];
	assign vblank = core_vblank[core_sel];

	// Two bit colour repeated to fill eight bits
	assign vga_r = {4{core_r[col_base +: 2]}};
	assign vga_g = {4{core_g[col_base +: 2]}};
	assign vga_b = {4{core_b[col_base +: 2]}};

	// ==============================
	// Serial and SD toward the routers
	// ==============================
	assign sel_txd     = core_txd[core_sel];
	assign sel_rts     = core_rts[core_sel];
	assign sel_sd_cs   = core_sd_cs[core_sel];
	assign sel_sd_mosi = core_sd_mosi[core_sel];
	assign sel_sd_sck  = core_sd_sck[core_sel];
	assign sel_led     = core_led[core_sel];

endmodule

/* hw/serial_router.sv */
// User port pins follow the board pinout with RX on bit 0 and CTS on bit 3, and CTS stays low until the start-up count expires
`timescale 1ns/10ps

module serial_router #(
	parameter logic [23:0] init_timeout = 24'd50000
) (
	input  logic       clk_sys,
	input  logic       sys_reset,
	input  logic       port_user,
	input  logic       flow_en,
	input  logic       sel_txd,
	input  logic       sel_rts,
	input  logic       uart_rxd,
	input  logic       uart_cts,
	input  logic [6:0] user_in,
	output logic       core_rxd,
	output logic       core_cts,
	output logic       uart_txd,
	output logic       uart_rts,
	output logic [6:0] user_out
);

	logic [23:0] init_cnt;
	logic        init_done;
	logic        user_flow;
	logic        cts_mux;

	// ==============================
	// Start-up hold-off
	// ==============================
	// Counts up once after reset and then parks
	// Done rises init_timeout+1 edges into the first run cycle
	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			init_cnt  <= '0;
			init_done <= 1'b0;
		end else if (!init_done) begin
			if (init_cnt == init_timeout) begin
				init_done <= 1'b1;
			end else begin
				init_cnt <= init_cnt + 24'd1;
			end
		end
	end

	// ==============================
	// Receive side
	// ==============================
	assign core_rxd = port_user ? user_in[0] : uart_rxd;

	// CTS from the active port only
	assign cts_mux = port_user ? user_in[3] : uart_cts;

	// Held low without flow control or before the hold-off ends
	assign core_cts = flow_en & init_done & cts_mux;

	// ==============================
	// Transmit side
	// ==============================
	// Idle port lines rest high
	assign uart_txd = port_user ? 1'b1 : sel_txd;
	assign uart_rts = (port_user | ~flow_en) ? 1'b1 : sel_rts;

	// Handshake on the user port
	assign user_flow = port_user & flow_en;

	// Bit 0 and bit 3 release the open-drain pins used as inputs
	assign user_out = {
		3'b000,
		user_flow,
		user_flow ? sel_rts : 1'b1,
		port_user ? sel_txd : 1'b1,
		port_user
	};

endmodule

/* hw/storage_router.sv */
// Assumes the SD bus runs on clk_sys so MOSI and MISO edges can be sampled directly for the activity LED
`timescale 1ns/10ps

module storage_router #(
	parameter int unsigned act_hold = 1000000
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       store_img,
	input  logic       vsd_sel,
	input  logic       sel_sd_cs,
	input  logic       sel_sd_mosi,
	input  logic       sel_sd_sck,
	input  logic       sel_led,
	input  logic       img_sd_cs,
	input  logic       img_sd_mosi,
	input  logic       img_sd_sck,
	input  logic       img_led,
	input  logic       vsd_miso,
	input  logic       sd_miso,
	output logic       sd_sck,
	output logic       sd_mosi,
	output logic       sd_cs,
	output logic       sd_oe,
	output logic       vsd_ss,
	output logic       core_sd_miso,
	output logic       led_user,
	output logic [1:0] led_disk
);

	localparam int act_width = $clog2(act_hold + 1);

	logic                 sck_mux;
	logic                 mosi_mux;
	logic                 cs_mux;
	logic                 led_mux;
	logic                 miso_mux;
	logic                 mosi_q;
	logic                 miso_q;
	logic                 bus_change;
	logic [act_width-1:0] act_cnt;
	logic                 sd_act;

	// ==============================
	// Controller select
	// ==============================
	// Image controller or the selected core's SD controller
	assign {sck_mux, mosi_mux, cs_mux, led_mux} = store_img
		? {img_sd_sck, img_sd_mosi, img_sd_cs, img_led}
		: {sel_sd_sck, sel_sd_mosi, sel_sd_cs, sel_led};

	// Virtual card answers once an image is mounted
	assign miso_mux = vsd_sel ? vsd_miso : sd_miso;

	assign sd_sck       = sck_mux;
	assign sd_mosi      = mosi_mux;
	assign sd_cs        = cs_mux;
	assign core_sd_miso = miso_mux;

	// Pins stay driven for the core controller or a virtual card
	assign sd_oe = vsd_sel | ~store_img;

	// Virtual card deselected when no image is present
	assign vsd_ss = cs_mux | ~vsd_sel;

	// ==============================
	// Bus activity
	// ==============================
	// Previous cycle of each data line
	always_ff @(posedge clk_sys) begin
		mosi_q <= mosi_mux;
		miso_q <= miso_mux;
	end

	assign bus_change = (mosi_q ^ mosi_mux) | (miso_q ^ miso_mux);

	// Any edge restarts the hold window
	// Counter saturates at act_hold when the bus is quiet
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			act_cnt <= act_width'(act_hold);
			sd_act  <= 1'b0;
		end else begin
			sd_act <= (act_cnt < act_width'(act_hold));
			if (bus_change) begin
				act_cnt <= '0;
			end else if (act_cnt < act_width'(act_hold)) begin
				act_cnt <= act_cnt + 1'b1;
			end
		end
	end

	// LEDs
	assign led_user = vsd_sel & sd_act;
	assign led_disk = {2{~led_mux}};

endmodule

/* hw/multicomp_glue.sv */
// Board glue only, so the cores, image controller and virtual card sit outside and connect through these ports
`timescale 1ns/10ps

module multicomp_glue
	import multicomp_pkg::*;
#(
	parameter logic [23:0] init_timeout = 24'd50000,
	parameter int unsigned act_hold     = 1000000
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	// Host options and image mount
	input  logic [opt_width-1:0]      option_word,
	input  logic                      user_button,
	input  logic                      img_mounted,
	input  logic [63:0]               img_size,
	// Core control
	output logic [num_cores-1:0]      core_run,
	output logic [num_cores-1:0]      core_reset,
	output logic [baud_inc_width-1:0] baud_inc,
	// Core outputs
	input  logic [num_cores-1:0]      core_pix_ce,
	input  logic [num_cores-1:0]      core_hs,
	input  logic [num_cores-1:0]      core_vs,
	input  logic [num_cores-1:0]      core_hblank,
	input  logic [num_cores-1:0]      core_vblank,
	input  logic [num_cores-1:0]      core_txd,
	input  logic [num_cores-1:0]      core_rts,
	input  logic [num_cores-1:0]      core_sd_cs,
	input  logic [num_cores-1:0]      core_sd_mosi,
	input  logic [num_cores-1:0]      core_sd_sck,
	input  logic [num_cores-1:0]      core_led,
	input  logic [num_cores*2-1:0]    core_r,
	input  logic [num_cores*2-1:0]    core_g,
	input  logic [num_cores*2-1:0]    core_b,
	// Video
	output logic                      pix_ce,
	output logic                      hs,
	output logic                      vs,
	output logic                      hblank,
	output logic                      vblank,
	output logic [7:0]                vga_r,
	output logic [7:0]                vga_g,
	output logic [7:0]                vga_b,
	// Serial
	input  logic                      uart_rxd,
	input  logic                      uart_cts,
	input  logic [6:0]                user_in,
	output logic                      core_rxd,
	output logic                      core_cts,
	output logic                      uart_txd,
	output logic                      uart_rts,
	output logic [6:0]                user_out,
	// Storage
	input  logic                      img_sd_cs,
	input  logic                      img_sd_mosi,
	input  logic                      img_sd_sck,
	input  logic                      img_led,
	input  logic                      vsd_miso,
	input  logic                      sd_miso,
	output logic                      sd_sck,
	output logic                      sd_mosi,
	output logic                      sd_cs,
	output logic                      sd_oe,
	output logic                      vsd_ss,
	output logic                      core_sd_miso,
	output logic                      led_user,
	output logic [1:0]                led_disk
);

	logic [1:0] core_sel;
	logic       port_user;
	logic       flow_en;
	logic       store_img;
	logic       sys_reset;
	logic       vsd_sel;
	logic       sel_txd;
	logic       sel_rts;
	logic       sel_sd_cs;
	logic       sel_sd_mosi;
	logic       sel_sd_sck;
	logic       sel_led;

	// ==============================
	// Options and reset
	// ==============================
	option_decode u_option_decode (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.option_word (option_word),
		.user_button (user_button),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.core_sel    (core_sel),
		.baud_inc    (baud_inc),
		.port_user   (port_user),
		.flow_en     (flow_en),
		.store_img   (store_img),
		.sys_reset   (sys_reset),
		.vsd_sel     (vsd_sel)
	);

	// ==============================
	// Core mux
	// ==============================
	core_select u_core_select (
		.core_sel     (core_sel),
		.sys_reset    (sys_reset),
		.core_run     (core_run),
		.core_reset   (core_reset),
		.core_pix_ce  (core_pix_ce),
		.core_hs      (core_hs),
		.core_vs      (core_vs),
		.core_hblank  (core_hblank),
		.core_vblank  (core_vblank),
		.core_txd     (core_txd),
		.core_rts     (core_rts),
		.core_sd_cs   (core_sd_cs),
		.core_sd_mosi (core_sd_mosi),
		.core_sd_sck  (core_sd_sck),
		.core_led     (core_led),
		.core_r       (core_r),
		.core_g       (core_g),
		.core_b       (core_b),
		.pix_ce       (pix_ce),
		.hs           (hs),
		.vs           (vs),
		.hblank       (hblank),
		.vblank       (vblank),
		.vga_r        (vga_r),
		.vga_g        (vga_g),
		.vga_b        (vga_b),
		.sel_txd      (sel_txd),
		.sel_rts      (sel_rts),
		.sel_sd_cs    (sel_sd_cs),
		.sel_sd_mosi  (sel_sd_mosi),
		.sel_sd_sck   (sel_sd_sck),
		.sel_led      (sel_led)
	);

	// ==============================
	// Serial and storage routing
	// ==============================
	serial_router #(
		.init_timeout (init_timeout)
	) u_serial_router (
		.clk_sys   (clk_sys),
		.sys_reset (sys_reset),
		.port_user (port_user),
		.flow_en   (flow_en),
		.sel_txd   (sel_txd),
		.sel_rts   (sel_rts),
		.uart_rxd  (uart_rxd),
		.uart_cts  (uart_cts),
		.user_in   (user_in),
		.core_rxd  (core_rxd),
		.core_cts  (core_cts),
		.uart_txd  (uart_txd),
		.uart_rts  (uart_rts),
		.user_out  (user_out)
	);

	// Activity timer runs from the board reset
	storage_router #(
		.act_hold (act_hold)
	) u_storage_router (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.store_img    (store_img),
		.vsd_sel      (vsd_sel),
		.sel_sd_cs    (sel_sd_cs),
		.sel_sd_mosi  (sel_sd_mosi),
		.sel_sd_sck   (sel_sd_sck),
		.sel_led      (sel_led),
		.img_sd_cs    (img_sd_cs),
		.img_sd_mosi  (img_sd_mosi),
		.img_sd_sck   (img_sd_sck),
		.img_led      (img_led),
		.vsd_miso     (vsd_miso),
		.sd_miso      (sd_miso),
		.sd_sck       (sd_sck),
		.sd_mosi      (sd_mosi),
		.sd_cs        (sd_cs),
		.sd_oe        (sd_oe),
		.vsd_ss       (vsd_ss),
		.core_sd_miso (core_sd_miso),
		.led_user     (led_user),
		.led_disk     (led_disk)
	);

endmodule

/* testbench/multicomp_checker.sv */
// Compares the DUT ports two rising edges after chk_go is seen, led_exp value 2 leaves led_user unchecked
`timescale 1ns/10ps

module multicomp_checker (
	input  logic        clk_sys,
	input  logic        chk_go,
	input  int          row_idx,
	input  logic [23:0] exp_ctl,
	input  logic [28:0] exp_vid,
	input  logic [10:0] exp_ser,
	input  logic [7:0]  exp_sto,
	input  logic [1:0]  led_exp,
	input  logic [3:0]  core_run,
	input  logic [3:0]  core_reset,
	input  logic [15:0] baud_inc,
	input  logic        pix_ce,
	input  logic        hs,
	input  logic        vs,
	input  logic        hblank,
	input  logic        vblank,
	input  logic [7:0]  vga_r,
	input  logic [7:0]  vga_g,
	input  logic [7:0]  vga_b,
	input  logic        core_rxd,
	input  logic        core_cts,
	input  logic        uart_txd,
	input  logic        uart_rts,
	input  logic [6:0]  user_out,
	input  logic        sd_sck,
	input  logic        sd_mosi,
	input  logic        sd_cs,
	input  logic        sd_oe,
	input  logic        vsd_ss,
	input  logic        core_sd_miso,
	input  logic        led_user,
	input  logic [1:0]  led_disk,
	output int          pass_cnt,
	output int          fail_cnt
);

	initial begin
		pass_cnt = 0;
		fail_cnt = 0;
	end

	// Mismatch report for one group of ports
	function automatic int check_group(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t row %0d %s got %h expected %h", $time, row_idx, name, got, exp);
			return 1;
		end
		return 0;
	endfunction

	// ==============================
	// Row compare
	// ==============================
	always @(posedge clk_sys) begin
		int errs;
		if (chk_go) begin
			@(posedge clk_sys);
			#1;
			errs = 0;
			errs += check_group("run/reset/baud", {core_run, core_reset, baud_inc}, exp_ctl);
			errs += check_group("video",
				{pix_ce, hs, vs, hblank, vblank, vga_r, vga_g, vga_b}, exp_vid);
			errs += check_group("serial",
				{core_rxd, core_cts, uart_txd, uart_rts, user_out}, exp_ser);
			errs += check_group("storage",
				{sd_sck, sd_mosi, sd_cs, sd_oe, vsd_ss, core_sd_miso, led_disk}, exp_sto);
			if (led_exp != 2'd2) begin
				errs += check_group("led_user", led_user, led_exp[0]);
			end
			if (errs == 0) begin
				pass_cnt++;
				$display("Row %0d ok at %0t", row_idx, $time);
			end else begin
				fail_cnt++;
			end
		end
	end

endmodule

/* testbench/multicomp_asserts.sv */
// Bound twice, unused inputs of each binding are tied to levels that keep the other checks quiet
`timescale 1ns/10ps

module multicomp_asserts (
	input logic clk_sys,
	input logic port_user,
	input logic uart_txd,
	input logic core_cts,
	input logic init_done,
	input logic store_img,
	input logic sd_oe
);

	// Core SD controller always drives the pins
	a_oe_core: assert property (@(posedge clk_sys) !store_img |-> sd_oe)
		else $error("sd_oe low while the core SD controller is selected");

	// Console TX parks high on the user port path
	a_txd_idle: assert property (@(posedge clk_sys) port_user |-> uart_txd)
		else $error("uart_txd low while the user port is selected");

	// No CTS before the start-up hold-off ends
	a_cts_hold: assert property (@(posedge clk_sys) !init_done |-> !core_cts)
		else $error("core_cts high before init_done");

endmodule

bind serial_router multicomp_asserts u_serial_asserts (
	.clk_sys   (clk_sys),
	.port_user (port_user),
	.uart_txd  (uart_txd),
	.core_cts  (core_cts),
	.init_done (init_done),
	.store_img (1'b1),
	.sd_oe     (1'b1)
);

bind storage_router multicomp_asserts u_storage_asserts (
	.clk_sys   (clk_sys),
	.port_user (1'b0),
	.uart_txd  (1'b1),
	.core_cts  (1'b0),
	.init_done (1'b1),
	.store_img (store_img),
	.sd_oe     (sd_oe)
);

/* testbench/tb_multicomp_glue.sv */
// Runs the glue top with short timers (init_timeout 40, act_hold 30) and random core patterns from a fixed seed
`timescale 1ns/10ps

module tb_multicomp_glue;
	import multicomp_pkg::*;

	localparam int num_rows = 16;
	localparam int t_init = 40;
	localparam int t_act = 30;
	// Cycle budget for the whole run
	localparam int cycle_limit = 3 * (num_rows * 4 + t_init + t_act);

	typedef struct packed {
		logic [31:0] opt;
		logic        btn;
		logic        mnt;
		logic        size_nz;
		logic [3:0]  img;      // sck, mosi, cs, led of the image controller
		logic [1:0]  miso;     // vsd_miso, sd_miso
		logic [7:0]  hold;     // Idle cycles before the check
		logic        cts_live; // Hold-off expected to be over
		logic [1:0]  led_exp;  // 0 or 1 expected, 2 not checked
	} stim_t;

	logic clk_sys, reset, user_button, img_mounted;
	logic [opt_width-1:0] option_word;
	logic [63:0] img_size;
	logic [num_cores-1:0] core_run, core_reset, core_pix_ce, core_hs, core_vs;
	logic [num_cores-1:0] core_hblank, core_vblank, core_txd, core_rts;
	logic [num_cores-1:0] core_sd_cs, core_sd_mosi, core_sd_sck, core_led;
	logic [num_cores*2-1:0] core_r, core_g, core_b;
	logic [baud_inc_width-1:0] baud_inc;
	logic pix_ce, hs, vs, hblank, vblank;
	logic [7:0] vga_r, vga_g, vga_b;
	logic uart_rxd, uart_cts, core_rxd, core_cts, uart_txd, uart_rts;
	logic [6:0] user_in, user_out;
	logic img_sd_cs, img_sd_mosi, img_sd_sck, img_led, vsd_miso, sd_miso;
	logic sd_sck, sd_mosi, sd_cs, sd_oe, vsd_ss, core_sd_miso, led_user;
	logic [1:0] led_disk;

	// Checker handshake and expected values
	logic chk_go;
	int row_idx;
	logic [23:0] exp_ctl;
	logic [28:0] exp_vid;
	logic [10:0] exp_ser;
	logic [7:0] exp_sto;
	logic [1:0] led_exp;
	int pass_cnt, fail_cnt;

	stim_t rows [num_rows];
	logic vsd_model;
	int cycles;

	multicomp_glue #(.init_timeout(24'd40), .act_hold(30)) DUT (.*);

	multicomp_checker u_checker (.*);

	// ==============================
	// Clock and timeout
	// ==============================
	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Option word from its fields
	function automatic logic [31:0] make_option(input logic [1:0] core, input logic [2:0] baud,
		input logic port, input logic store, input logic flow, input logic mres, input logic rbit);
		logic [31:0] w;
		w = '0;
		w[8:7] = core;
		w[11:9] = baud;
		w[12] = port;
		w[13] = store;
		w[14] = flow;
		w[15] = mres;
		w[0] = rbit;
		return w;
	endfunction

	// Baud increments for codes 0 to 5, spare codes at 115200
	function automatic logic [15:0] baud_expect(input logic [2:0] code);
		case (code)
			3'd1: return 16'd805;
			3'd2: return 16'd403;
			3'd3: return 16'd201;
			3'd4: return 16'd101;
			3'd5: return 16'd50;
			default: return 16'd2416;
		endcase
	endfunction

	// Drives one row and works out what the ports must show
	task automatic apply_row(input int i);
		stim_t s;
		logic [1:0] sel;
		logic port, store, flow, rst, cts_src, pf, sck, mosi, cs, led;
		logic [3:0] run;
		s = rows[i];
		option_word = s.opt;
		user_button = s.btn;
		img_mounted = s.mnt;
		img_size = s.size_nz ? ({$urandom, $urandom} | 64'd1) : 64'd0;
		{img_sd_sck, img_sd_mosi, img_sd_cs, img_led} = s.img;
		{vsd_miso, sd_miso} = s.miso;
		{core_pix_ce, core_hs, core_vs, core_hblank} = $urandom;
		{core_vblank, core_txd, core_rts, core_sd_cs} = $urandom;
		{core_sd_mosi, core_sd_sck, core_led} = $urandom;
		{core_r, core_g, core_b} = $urandom;
		{uart_rxd, uart_cts, user_in} = $urandom;
		sel = s.opt[8:7];
		port = s.opt[12];
		store = s.opt[13];
		flow = s.opt[14];
		// Both CTS sources high with flow control so the hold-off gate shows
		if (flow) begin
			uart_cts = 1'b1;
			user_in[3] = 1'b1;
		end
		rst = s.opt[0] | s.btn | (s.opt[15] & s.mnt);
		if (s.mnt) begin
			vsd_model = s.size_nz;
		end
		run = 4'b0001 << sel;
		exp_ctl = {run, rst ? 4'hf : ~run, baud_expect(s.opt[11:9])};
		exp_vid = {core_pix_ce[sel], core_hs[sel], core_vs[sel], core_hblank[sel],
			core_vblank[sel], {4{core_r[sel*2 +: 2]}}, {4{core_g[sel*2 +: 2]}},
			{4{core_b[sel*2 +: 2]}}};
		cts_src = port ? user_in[3] : uart_cts;
		pf = port & flow;
		exp_ser = {port ? user_in[0] : uart_rxd, s.cts_live & flow & cts_src,
			port ? 1'b1 : core_txd[sel], (port | ~flow) ? 1'b1 : core_rts[sel],
			3'b000, pf, pf ? core_rts[sel] : 1'b1, port ? core_txd[sel] : 1'b1, port};
		{sck, mosi, cs, led} = store ? s.img
			: {core_sd_sck[sel], core_sd_mosi[sel], core_sd_cs[sel], core_led[sel]};
		exp_sto = {sck, mosi, cs, vsd_model | ~store, cs | ~vsd_model,
			vsd_model ? s.miso[1] : s.miso[0], ~led, ~led};
		led_exp = s.led_exp;
	endtask

	// ==============================
	// Stimulus table and sequence
	// ==============================
	initial begin
		void'($urandom(32'hb915));
		{reset, user_button, img_mounted, option_word, img_size} = '0;
		reset = 1'b1;
		{core_pix_ce, core_hs, core_vs, core_hblank, core_vblank} = '0;
		{core_txd, core_rts, core_sd_cs, core_sd_mosi, core_sd_sck, core_led} = '0;
		{core_r, core_g, core_b, uart_rxd, uart_cts, user_in} = '0;
		{img_sd_cs, img_sd_mosi, img_sd_sck, img_led, vsd_miso, sd_miso} = '0;
		{chk_go, row_idx, exp_ctl, exp_vid, exp_ser, exp_sto, led_exp} = '0;
		vsd_model = 1'b0;
		cycles = 0;
		// Core, baud, port, store, flow, mount reset, reset bit
		rows[0]  = '{make_option(0, 0, 0, 0, 1, 0, 0), 0, 0, 0, 4'b0000, 2'b00, 0, 0, 0};
		rows[1]  = '{make_option(1, 1, 0, 0, 0, 0, 0), 0, 0, 0, 4'b1010, 2'b01, 0, 0, 0};
		rows[2]  = '{make_option(2, 2, 1, 0, 0, 0, 0), 0, 0, 0, 4'b0101, 2'b10, 0, 0, 0};
		rows[3]  = '{make_option(3, 3, 1, 0, 1, 0, 0), 0, 0, 0, 4'b0000, 2'b11, 0, 0, 0};
		rows[4]  = '{make_option(0, 4, 0, 1, 0, 0, 0), 0, 1, 1, 4'b1001, 2'b00, 0, 0, 2};
		rows[5]  = '{make_option(1, 5, 0, 1, 0, 0, 0), 0, 0, 0, 4'b0110, 2'b10, 0, 0, 2};
		rows[6]  = '{make_option(2, 6, 0, 1, 0, 0, 0), 0, 0, 0, 4'b0000, 2'b10, 0, 0, 2};
		// MOSI toggle then a long quiet stretch
		rows[7]  = '{make_option(2, 7, 0, 1, 0, 0, 0), 0, 0, 0, 4'b0100, 2'b10, 0, 0, 1};
		rows[8]  = '{make_option(2, 7, 0, 1, 0, 0, 0), 0, 0, 0, 4'b0100, 2'b10, 60, 0, 0};
		rows[9]  = '{make_option(3, 0, 0, 0, 0, 0, 0), 0, 1, 0, 4'b0011, 2'b01, 0, 0, 0};
		// Mount reset option alone must not reset the system
		rows[10] = '{make_option(3, 1, 0, 1, 0, 1, 0), 0, 0, 0, 4'b1111, 2'b01, 0, 0, 0};
		// Reset sources
		rows[11] = '{make_option(0, 2, 0, 0, 0, 0, 1), 0, 0, 0, 4'b0000, 2'b00, 0, 0, 0};
		rows[12] = '{make_option(1, 3, 0, 0, 0, 0, 0), 1, 0, 0, 4'b0000, 2'b00, 0, 0, 0};
		rows[13] = '{make_option(2, 4, 0, 0, 0, 1, 0), 0, 1, 1, 4'b0000, 2'b10, 0, 0, 2};
		// CTS once the hold-off has run out
		rows[14] = '{make_option(0, 0, 0, 0, 1, 0, 0), 0, 0, 0, 4'b0000, 2'b10, 80, 1, 0};
		rows[15] = '{make_option(3, 0, 1, 0, 1, 0, 0), 0, 0, 0, 4'b0000, 2'b10, 0, 1, 2};
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		for (int i = 0; i < num_rows; i++) begin
			@(negedge clk_sys);
			row_idx = i;
			apply_row(i);
			repeat (rows[i].hold) @(negedge clk_sys);
			chk_go = 1'b1;
			@(negedge clk_sys);
			chk_go = 1'b0;
			@(negedge clk_sys);
		end
		$display("Rows passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt == num_rows) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* project.f */
hw/multicomp_pkg.sv
hw/option_decode.sv
hw/core_select.sv
hw/serial_router.sv
hw/storage_router.sv
hw/multicomp_glue.sv
testbench/multicomp_checker.sv
testbench/multicomp_asserts.sv
testbench/tb_multicomp_glue.sv

/* Bender.yml */
package:
  name: multicomp_glue

sources:
  - hw/multicomp_pkg.sv
  - hw/option_decode.sv
  - hw/core_select.sv
  - hw/serial_router.sv
  - hw/storage_router.sv
  - hw/multicomp_glue.sv
  - target: simulation
    files:
      - testbench/multicomp_checker.sv
      - testbench/multicomp_asserts.sv
      - testbench/tb_multicomp_glue.sv
